//--- verilog/accel_cfg.svh
`ifndef ACCEL_CFG_SVH
`define ACCEL_CFG_SVH

`default_nettype none

// ==============================
// datapath sizes
// ==============================
`define ACCEL_NUM_PE     4   // MAC lanes, one output neuron each
`define ACCEL_OP_W       16  // signed operand and weight
`define ACCEL_ACC_W      40

// ==============================
// control sizes
// ==============================
`define ACCEL_WB_ADDR_W  10  // 1024 weight rows
`define ACCEL_COUNT_W    10
`define ACCEL_SHIFT_W    5
`define ACCEL_DRAIN_CYC  2   // last MAC issue to final accumulator

`default_nettype wire
`endif

//--- verilog/accel_data_pkg.sv
`include "accel_cfg.svh"
`default_nettype none

package accel_data_pkg;

  typedef logic signed [`ACCEL_OP_W-1:0]  operand_t;
  typedef operand_t [`ACCEL_NUM_PE-1:0]   weight_row_t;  // lane i in element i
  typedef logic signed [`ACCEL_ACC_W-1:0] acc_t;
  typedef logic [`ACCEL_COUNT_W-1:0]      count_t;
  typedef logic [`ACCEL_SHIFT_W-1:0]      shift_t;

  localparam int WORD_W    = `ACCEL_NUM_PE * `ACCEL_OP_W;
  localparam int CFG_PAD_W = WORD_W - `ACCEL_COUNT_W - `ACCEL_SHIFT_W - 1;

  // layer header, first word of every layer
  typedef struct packed {
    logic [CFG_PAD_W-1:0] reserved;
    logic                 relu;
    shift_t               shift;
    count_t               in_count;  // low bits
  } stream_cfg_t;

  // same 64 bits, read as cfg by the controller
  // and as packed operands by vector_gen
  typedef union packed {
    stream_cfg_t                  cfg;
    operand_t [`ACCEL_NUM_PE-1:0] data;  // lane 0 goes first
  } stream_word_t;

endpackage

`default_nettype wire

//--- verilog/accel_ctrl_pkg.sv
`include "accel_cfg.svh"
`default_nettype none

package accel_ctrl_pkg;

  typedef enum logic [2:0] {
    IDLE,
    CONFIG,  // wait for the layer header
    RUN,     // one MAC per valid operand
    DRAIN,
    WRITE,   // push result, waits on out_full
    FINISH
  } ctrl_state_t;

  typedef logic [`ACCEL_WB_ADDR_W-1:0] wb_addr_t;

endpackage

`default_nettype wire

//--- verilog/accel_controller.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module accel_controller
  import accel_data_pkg::*;
  import accel_ctrl_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               start,
  input  wire stream_word_t word,
  input  wire               word_valid,
  input  wire               op_valid,
  input  wire               out_full,
  output logic              done,
  output logic              op_take,
  output logic              word_take,
  output wb_addr_t          rd_addr,
  output logic              acc_clear,
  output logic              mac_en,
  output shift_t            shift,
  output logic              relu,
  output logic              out_push
);

  localparam int DRAIN_W = $clog2(`ACCEL_DRAIN_CYC + 1);
  localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`ACCEL_DRAIN_CYC - 1);

  ctrl_state_t        state;
  count_t             in_count;
  count_t             op_cnt;     // operands issued this layer
  logic [DRAIN_W-1:0] drain_cnt;
  logic               cfg_load;
  logic               last_op;

  assign cfg_load  = (state == CONFIG) && word_valid;
  assign last_op   = (op_cnt == in_count - count_t'(1));
  assign mac_en    = (state == RUN) && op_valid;
  assign op_take   = mac_en && !last_op;
  assign word_take = cfg_load || (mac_en && last_op);  // drop leftover lanes
  assign acc_clear = cfg_load;
  assign rd_addr   = wb_addr_t'(op_cnt);  // weight row k for operand k
  assign out_push  = (state == WRITE) && !out_full;
  assign done      = (state == FINISH);

  // ==============================
  // layer sequencing
  // ==============================
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= IDLE;
      op_cnt    <= '0;
      drain_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (start)
            state <= CONFIG;
        CONFIG:
          if (word_valid)
          begin
            op_cnt <= '0;
            // empty layer skips straight to the result
            state  <= (word.cfg.in_count == '0) ? DRAIN : RUN;
          end
        RUN:
          if (mac_en)
          begin
            op_cnt <= op_cnt + count_t'(1);
            if (last_op)
              state <= DRAIN;
          end
        DRAIN:
          if (drain_cnt == DRAIN_LAST)
          begin
            drain_cnt <= '0;
            state     <= WRITE;
          end
          else
            drain_cnt <= drain_cnt + 1'b1;
        WRITE:
          if (!out_full)
            state <= FINISH;
        FINISH:
          state <= IDLE;  // done pulses here
        default:
          state <= IDLE;
      endcase
    end
  end

  // header fields, held for the whole layer
  always_ff @(posedge clk)
  begin
    if (cfg_load)
    begin
      in_count <= word.cfg.in_count;
      shift    <= word.cfg.shift;
      relu     <= word.cfg.relu;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vector_gen.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module vector_gen
  import accel_data_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               stream_empty,
  input  wire stream_word_t stream_data,
  input  wire               op_take,
  input  wire               word_take,
  output logic              stream_pop,
  output stream_word_t      word,
  output logic              word_valid,
  output logic              op_valid,
  output operand_t          operand
);

  localparam int LANE_W = (`ACCEL_NUM_PE > 1) ? $clog2(`ACCEL_NUM_PE) : 1;
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`ACCEL_NUM_PE - 1);

  logic              held;       // a word sits in the register
  logic [LANE_W-1:0] lane;
  logic              word_done;

  assign word_done  = held && (word_take || (op_take && lane == LAST_LANE));
  // refill in the same cycle the old word goes, no bubble
  assign stream_pop = (!held || word_done) && !stream_empty;
  assign word_valid = held;
  assign op_valid   = held;
  assign operand    = word.data[lane];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      held <= 1'b0;
      lane <= '0;
    end
    else
    begin
      if (stream_pop)
        held <= 1'b1;
      else if (word_done)
        held <= 1'b0;
      if (word_done)
        lane <= '0;
      else if (op_take && held)
        lane <= lane + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (stream_pop)
      word <= stream_data;
  end

endmodule

`default_nettype wire

//--- verilog/weight_buffer.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module weight_buffer
  import accel_data_pkg::*;
  import accel_ctrl_pkg::*;
(
  input  wire              clk,
  input  wire              wb_write,
  input  wire wb_addr_t    wb_addr,
  input  wire weight_row_t wb_data,
  input  wire wb_addr_t    rd_addr,
  output weight_row_t      rd_data
);

  // one row holds a weight for every lane
  weight_row_t mem [2**`ACCEL_WB_ADDR_W];

  always_ff @(posedge clk)
  begin
    if (wb_write)
      mem[wb_addr] <= wb_data;  // loaded only while idle
    rd_data <= mem[rd_addr];    // one cycle read latency
  end

endmodule

`default_nettype wire

//--- verilog/pe_array.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module pe_array
  import accel_data_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              acc_clear,
  input  wire              mac_en,
  input  wire operand_t    operand,
  input  wire weight_row_t weight,
  input  wire shift_t      shift,
  input  wire              relu,
  output weight_row_t      out_data
);

  localparam acc_t SAT_MAX = acc_t'((1 << (`ACCEL_OP_W - 1)) - 1);
  localparam acc_t SAT_MIN = acc_t'(-(1 << (`ACCEL_OP_W - 1)));

  operand_t op_d;   // lined up with the registered weight row
  logic     mac_d;
  acc_t     acc    [`ACCEL_NUM_PE];
  acc_t     scaled [`ACCEL_NUM_PE];

  always_ff @(posedge clk)
  begin
    if (reset)
      mac_d <= 1'b0;
    else
      mac_d <= mac_en;
  end

  always_ff @(posedge clk)
  begin
    op_d <= operand;
  end

  // ==============================
  // MAC lanes
  // ==============================
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `ACCEL_NUM_PE; i++)
    begin
      if (acc_clear)
        acc[i] <= '0;
      else if (mac_d)
        acc[i] <= acc[i] + op_d * $signed(weight[i]);  // same operand on all lanes
    end
  end

  // shift, relu, then clip to operand range
  always_comb
  begin
    for (int i = 0; i < `ACCEL_NUM_PE; i++)
    begin
      scaled[i] = acc[i] >>> shift;
      if (relu && scaled[i] < 0)
        scaled[i] = '0;
      if (scaled[i] > SAT_MAX)
        out_data[i] = operand_t'(SAT_MAX);
      else if (scaled[i] < SAT_MIN)
        out_data[i] = operand_t'(SAT_MIN);
      else
        out_data[i] = operand_t'(scaled[i]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/dnn_accelerator.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module dnn_accelerator
  import accel_data_pkg::*;
  import accel_ctrl_pkg::*;
(
  input  wire               clk,
  input  wire               reset,
  input  wire               start,
  output logic              done,
  // input stream, FWFT
  input  wire               stream_empty,
  input  wire stream_word_t stream_data,
  output logic              stream_pop,
  // weight load port
  input  wire               wb_write,
  input  wire wb_addr_t     wb_addr,
  input  wire weight_row_t  wb_data,
  // output FIFO
  input  wire               out_full,
  output logic              out_push,
  output weight_row_t       out_data
);

  stream_word_t word;
  logic         word_valid;
  logic         op_valid;
  logic         op_take;
  logic         word_take;
  operand_t     operand;
  wb_addr_t     rd_addr;
  weight_row_t  weight;
  logic         acc_clear;
  logic         mac_en;
  shift_t       shift;
  logic         relu;

  // ==============================
  // control
  // ==============================
  accel_controller u_controller (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .start      ( start      ),
    .word       ( word       ),
    .word_valid ( word_valid ),
    .op_valid   ( op_valid   ),
    .out_full   ( out_full   ),
    .done       ( done       ),
    .op_take    ( op_take    ),
    .word_take  ( word_take  ),
    .rd_addr    ( rd_addr    ),
    .acc_clear  ( acc_clear  ),
    .mac_en     ( mac_en     ),
    .shift      ( shift      ),
    .relu       ( relu       ),
    .out_push   ( out_push   )
  );

  vector_gen u_vecgen (
    .clk          ( clk          ),
    .reset        ( reset        ),
    .stream_empty ( stream_empty ),
    .stream_data  ( stream_data  ),
    .op_take      ( op_take      ),
    .word_take    ( word_take    ),
    .stream_pop   ( stream_pop   ),
    .word         ( word         ),
    .word_valid   ( word_valid   ),
    .op_valid     ( op_valid     ),
    .operand      ( operand      )
  );

  // ==============================
  // datapath
  // ==============================
  weight_buffer u_wbuf (
    .clk      ( clk      ),
    .wb_write ( wb_write ),
    .wb_addr  ( wb_addr  ),
    .wb_data  ( wb_data  ),
    .rd_addr  ( rd_addr  ),
    .rd_data  ( weight   )
  );

  pe_array u_pe_array (
    .clk       ( clk       ),
    .reset     ( reset     ),
    .acc_clear ( acc_clear ),
    .mac_en    ( mac_en    ),
    .operand   ( operand   ),
    .weight    ( weight    ),
    .shift     ( shift     ),
    .relu      ( relu      ),
    .out_data  ( out_data  )
  );

endmodule

`default_nettype wire

//--- sim/tb_dnn_accelerator.sv
`timescale 1ns/100ps
`include "accel_cfg.svh"
`default_nettype none

module tb_dnn_accelerator;

  localparam int NUM_PE   = `ACCEL_NUM_PE;
  localparam int OP_W     = `ACCEL_OP_W;
  localparam int ROW_W    = NUM_PE * OP_W;
  localparam int MAX_CNT  = 40;  // longest layer in any test
  localparam int N_LAYERS = 16;
  // every layer at its largest, operands plus stream words
  localparam int WATCHDOG_CYC = 4 * N_LAYERS * (MAX_CNT + 1 + MAX_CNT / NUM_PE) + 200;

  logic                        clk;
  logic                        reset;
  logic                        start;
  logic                        done;
  logic                        stream_empty;
  logic [ROW_W-1:0]            stream_data;
  logic                        stream_pop;
  logic                        wb_write;
  logic [`ACCEL_WB_ADDR_W-1:0] wb_addr;
  logic [ROW_W-1:0]            wb_data;
  logic                        out_full;
  logic                        out_push;
  logic [ROW_W-1:0]            out_data;

  logic [ROW_W-1:0]       w_model [2**`ACCEL_WB_ADDR_W];  // copy of the weight rows
  logic signed [OP_W-1:0] ops [MAX_CNT];
  logic [ROW_W-1:0]       stream_q [$];  // words not yet popped
  logic [ROW_W-1:0]       expect_q [$];  // one result row per queued layer

  integer seed;
  integer gap_seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     pushes_in_layer;
  logic   push_prev;

  dnn_accelerator dut0 (
    .clk          ( clk          ),
    .reset        ( reset        ),
    .start        ( start        ),
    .done         ( done         ),
    .stream_empty ( stream_empty ),
    .stream_data  ( stream_data  ),
    .stream_pop   ( stream_pop   ),
    .wb_write     ( wb_write     ),
    .wb_addr      ( wb_addr      ),
    .wb_data      ( wb_data      ),
    .out_full     ( out_full     ),
    .out_push     ( out_push     ),
    .out_data     ( out_data     )
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int rand_range(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'($unsigned($random(seed)) % span);
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_low(input string name, input logic value);
    checks++;
    assert (value === 1'b0)
    else
    begin
      $display("[FAIL] %0t ns %s expected 0 got %b", $time, name, value);
      errors++;
    end
  endtask

  // upper half of the lanes negated when mirror_upper is set
  task automatic load_rows(input int n, input int lo, input int hi, input bit mirror_upper);
    logic [ROW_W-1:0] row;
    for (int a = 0; a < n; a++)
    begin
      for (int l = 0; l < NUM_PE; l++)
        if (mirror_upper && l >= NUM_PE / 2)
          row[l*OP_W +: OP_W] = OP_W'(-rand_range(lo, hi) - 1);
        else
          row[l*OP_W +: OP_W] = OP_W'(rand_range(lo, hi));
      @(posedge clk);
      wb_write <= 1'b1;
      wb_addr  <= a[`ACCEL_WB_ADDR_W-1:0];
      wb_data  <= row;
      w_model[a] = row;
    end
    @(posedge clk);
    wb_write <= 1'b0;
  endtask

  task automatic fill_ops(input int cnt, input int lo, input int hi);
    for (int k = 0; k < cnt; k++)
      ops[k] = OP_W'(rand_range(lo, hi));
  endtask

  // ==============================
  // layer model
  // ==============================
  task automatic queue_layer(input int cnt, input int sh, input bit rl);
    logic [ROW_W-1:0]       word;
    logic [ROW_W-1:0]       expect_row;
    logic signed [OP_W-1:0] w;
    longint                 acc;
    word        = '0;
    word[9:0]   = cnt[9:0];  // in_count
    word[14:10] = sh[4:0];
    word[15]    = rl;
    stream_q.push_back(word);
    for (int k0 = 0; k0 < cnt; k0 += NUM_PE)
    begin
      for (int l = 0; l < NUM_PE; l++)
        if (k0 + l < cnt)
          word[l*OP_W +: OP_W] = ops[k0 + l];
        else
          word[l*OP_W +: OP_W] = OP_W'(rand_range(-32768, 32767));  // junk past the end
      stream_q.push_back(word);
    end
    for (int l = 0; l < NUM_PE; l++)
    begin
      acc = 0;
      for (int k = 0; k < cnt; k++)
      begin
        w   = w_model[k][l*OP_W +: OP_W];
        acc += longint'(ops[k]) * longint'(w);
      end
      acc = acc >>> sh;
      if (rl && acc < 0)
        acc = 0;
      if (acc > 32767)
        acc = 32767;
      else if (acc < -32768)
        acc = -32768;
      expect_row[l*OP_W +: OP_W] = acc[OP_W-1:0];
    end
    expect_q.push_back(expect_row);
  endtask

  task automatic run_layers(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      do
        @(posedge clk);
      while (done !== 1'b1);
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    @(negedge clk);  // monitor has seen the last edge
    assert (expect_q.size() == 0) else report_error("a layer result never came out");
    assert (stream_q.size() == 0) else report_error("stream words were left unread");
    tests_run++;
    if (errors == err_start)
      $display("test %0d, %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d, %s: %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  // ==============================
  // stream, output FIFO, checks
  // ==============================
  always @(posedge clk)
  begin
    integer           r;
    logic [ROW_W-1:0] expect_row;
    r = $random(gap_seed);
    if (!reset)
    begin
      if (stream_pop === 1'b1)
      begin
        assert (stream_empty === 1'b0) else report_error("stream popped while empty");
        if (stream_q.size() > 0 && !stream_empty)
          stream_q.delete(0);
      end
      if (push_prev)
        assert (done === 1'b1) else report_error("done did not follow the push");
      push_prev = (out_push === 1'b1);
      if (out_push === 1'b1)
      begin
        assert (out_full === 1'b0) else report_error("push while out_full was high");
        assert (pushes_in_layer == 0) else report_error("second push in one layer");
        pushes_in_layer++;
        if (expect_q.size() == 0)
          report_error("push with no layer pending");
        else
        begin
          expect_row = expect_q.pop_front();
          checks++;
          assert (out_data === expect_row)
          else
          begin
            $display("[FAIL] %0t ns out_data expected %h got %h", $time, expect_row, out_data);
            errors++;
          end
        end
      end
      if (done === 1'b1)
      begin
        assert (pushes_in_layer != 0) else report_error("done without a push");
        pushes_in_layer = 0;
      end
    end
    stream_empty <= (stream_q.size() == 0) || (r[1:0] == 2'b00);  // random gaps
    if (stream_q.size() > 0)
      stream_data <= stream_q[0];
    out_full <= (r[3:2] == 2'b00);
  end

  initial
  begin
    int err_start;
    int cnt;
    int sh;
    int rl;
    seed            = 64;
    gap_seed        = $random(seed);
    reset           = 1'b1;
    start           = 1'b0;
    stream_empty    = 1'b1;
    stream_data     = '0;
    wb_write        = 1'b0;
    wb_addr         = '0;
    wb_data         = '0;
    out_full        = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    pushes_in_layer = 0;
    push_prev       = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    err_start = errors;
    repeat (10)
    begin
      @(posedge clk);
      check_low("done", done);
      check_low("stream_pop", stream_pop);
      check_low("out_push", out_push);
    end
    end_test("outputs quiet after reset", err_start);

    err_start = errors;
    load_rows(NUM_PE, -8, 7, 1'b0);
    fill_ops(NUM_PE, -8, 7);
    queue_layer(NUM_PE, 0, 1'b0);
    run_layers(1);
    end_test("single small layer", err_start);

    // ==============================
    // shift, relu, saturation
    // ==============================
    err_start = errors;
    load_rows(MAX_CNT, -300, 300, 1'b0);
    repeat (6)
    begin
      cnt = rand_range(1, MAX_CNT);
      sh  = rand_range(0, 8);
      rl  = rand_range(0, 1);
      fill_ops(cnt, -300, 300);
      queue_layer(cnt, sh, rl[0]);
      run_layers(1);
    end
    end_test("random shift and relu", err_start);

    err_start = errors;
    load_rows(8, 30000, 32767, 1'b1);  // lanes 0,1 high, lanes 2,3 low
    fill_ops(8, 30000, 32767);
    queue_layer(8, 0, 1'b0);
    fill_ops(8, -32768, -30000);  // sign flipped, every lane hits the other limit
    queue_layer(8, 8, 1'b0);
    run_layers(2);
    end_test("saturation limits", err_start);

    err_start = errors;
    load_rows(MAX_CNT, -300, 300, 1'b0);
    repeat (5)
    begin
      cnt = NUM_PE * rand_range(0, MAX_CNT / NUM_PE - 1) + rand_range(1, NUM_PE - 1);
      sh  = rand_range(0, 8);
      rl  = rand_range(0, 1);
      fill_ops(cnt, -300, 300);
      queue_layer(cnt, sh, rl[0]);
    end
    run_layers(5);
    end_test("back-to-back ragged layers", err_start);

    err_start = errors;
    load_rows(16, -100, 100, 1'b0);
    fill_ops(13, -100, 100);
    queue_layer(13, 2, 1'b0);
    run_layers(1);
    load_rows(16, -100, 100, 1'b0);  // same operands, new rows
    queue_layer(13, 2, 1'b0);
    run_layers(1);
    end_test("weight reload", err_start);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/accel_data_pkg.sv
verilog/accel_ctrl_pkg.sv
verilog/accel_controller.sv
verilog/vector_gen.sv
verilog/weight_buffer.sv
verilog/pe_array.sv
verilog/dnn_accelerator.sv
sim/tb_dnn_accelerator.sv

//--- Bender.yml
package:
  name: dnn_accelerator

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/accel_data_pkg.sv
      - verilog/accel_ctrl_pkg.sv
      - verilog/accel_controller.sv
      - verilog/vector_gen.sv
      - verilog/weight_buffer.sv
      - verilog/pe_array.sv
      - verilog/dnn_accelerator.sv

  - target: test
    files:
      - sim/tb_dnn_accelerator.sv
